//--- all.f
hw/udp_msg_pkg.sv
hw/udp_msg_if.sv
hw/msg_header_parser.sv
hw/msg_payload_collector.sv
hw/msg_reply_sender.sv
hw/udp_msg_endpoint.sv
sim/tb_udp_msg_endpoint.sv

//--- hw/msg_header_parser.sv
module msg_header_parser (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rx_head_av_i,
    input  logic [31:0]       rx_head_i,
    output logic              rx_head_rdy_o,
    reply_target_if.parser    tgt
);

    udp_msg_pkg::hdr_state_e state;

    assign tgt.valid = (state == udp_msg_pkg::HDR_PAYLOAD);

    // first header word is sampled at the end of the rdy cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= udp_msg_pkg::HDR_IDLE;
            rx_head_rdy_o <= 1'b0;
        end else begin
            rx_head_rdy_o <= 1'b0;
            case (state)
                udp_msg_pkg::HDR_IDLE: begin
                    if (rx_head_av_i) begin
                        rx_head_rdy_o <= 1'b1;
                        state <= udp_msg_pkg::HDR_IP_WORD;
                    end
                end
                udp_msg_pkg::HDR_IP_WORD: begin
                    state <= udp_msg_pkg::HDR_LEN_WORD;
                end
                udp_msg_pkg::HDR_LEN_WORD: begin
                    state <= udp_msg_pkg::HDR_PORT_WORD;
                end
                udp_msg_pkg::HDR_PORT_WORD: begin
                    // wrong port drops the datagram here
                    if (rx_head_i[15:0] == udp_msg_pkg::LOCAL_PORT) begin
                        state <= udp_msg_pkg::HDR_PAYLOAD;
                    end else begin
                        state <= udp_msg_pkg::HDR_IDLE;
                    end
                end
                udp_msg_pkg::HDR_PAYLOAD: begin
                    if (tgt.done) begin
                        state <= udp_msg_pkg::HDR_IDLE;
                    end
                end
                default: begin
                    state <= udp_msg_pkg::HDR_IDLE;
                end
            endcase
        end
    end

    // reply target, source port goes back as destination
    always_ff @(posedge clk) begin
        if (state == udp_msg_pkg::HDR_IP_WORD) begin
            tgt.ip <= rx_head_i;
        end
        if (state == udp_msg_pkg::HDR_PORT_WORD) begin
            tgt.port <= rx_head_i[31:16];
        end
    end

    a_rdy_single: assert property (@(posedge clk) disable iff (!rst_n)
        rx_head_rdy_o |=> !rx_head_rdy_o);

    a_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        tgt.valid && !tgt.done |=> tgt.valid);

    a_valid_after_header: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(tgt.valid) |-> $past(rx_head_rdy_o, udp_msg_pkg::HEAD_WORDS));

endmodule

//--- hw/msg_payload_collector.sv
module msg_payload_collector (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rx_data_av_i,
    input  logic [7:0]          rx_data_i,
    reply_target_if.collector   tgt,
    reply_start_if.collector    rs,
    output udp_msg_pkg::msg_t   rx_msg_o,
    output logic                msg_valid_o
);

    udp_msg_pkg::msg_t  shift_q;
    udp_msg_pkg::bcnt_t byte_cnt;
    logic               dgram_end;
    logic               id_ok;

    // first idle cycle after at least one byte
    assign dgram_end = tgt.valid && !rx_data_av_i && (byte_cnt != '0);

    // short datagrams never reach a full count
    assign id_ok = (byte_cnt == udp_msg_pkg::BCNT_FULL) &&
                   (shift_q[udp_msg_pkg::MSG_W-1 -: 32] == udp_msg_pkg::MSGID);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt <= '0;
            tgt.done <= 1'b0;
            rs.start <= 1'b0;
            msg_valid_o <= 1'b0;
            rx_msg_o <= '0;
        end else begin
            tgt.done <= 1'b0;
            rs.start <= 1'b0;
            msg_valid_o <= 1'b0;
            if (tgt.valid && rx_data_av_i) begin
                if (byte_cnt != udp_msg_pkg::BCNT_FULL) begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end else if (dgram_end) begin
                byte_cnt <= '0;
                tgt.done <= 1'b1;
                if (id_ok) begin
                    rx_msg_o <= shift_q;
                    msg_valid_o <= 1'b1;
                    // no second reply while one is in flight
                    rs.start <= !rs.busy;
                end
            end
        end
    end

    // keeps only the last MSG_BYTES bytes
    always_ff @(posedge clk) begin
        if (tgt.valid && rx_data_av_i) begin
            shift_q <= {shift_q[udp_msg_pkg::MSG_W-9:0], rx_data_i};
        end
        if (dgram_end) begin
            rs.ip <= tgt.ip;
            rs.port <= tgt.port;
        end
    end

    a_no_start_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        rs.start |-> !rs.busy);

endmodule

//--- hw/msg_reply_sender.sv
module msg_reply_sender (
    input  logic              clk,
    input  logic              rst_n,
    reply_start_if.sender     rs,
    input  udp_msg_pkg::msg_t tx_msg_i,
    input  logic              tx_req_rdy_i,
    input  logic              tx_data_rdy_i,
    output logic [7:0]        tx_data_o,
    output logic              tx_data_av_o,
    output logic              tx_req_o,
    output logic [31:0]       tx_ip_o,
    output logic [15:0]       tx_dst_port_o
);

    udp_msg_pkg::tx_state_e state;
    udp_msg_pkg::msg_t      msg_q;
    udp_msg_pkg::bcnt_t     byte_cnt;
    logic                   advance;

    assign rs.busy = (state != udp_msg_pkg::TX_IDLE);

    // a byte moves when av and rdy are both high, or the output is empty
    assign advance = (state == udp_msg_pkg::TX_STREAM) &&
                     (!tx_data_av_o || tx_data_rdy_i);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= udp_msg_pkg::TX_IDLE;
            byte_cnt <= '0;
            tx_data_av_o <= 1'b0;
            tx_req_o <= 1'b0;
        end else begin
            case (state)
                udp_msg_pkg::TX_IDLE: begin
                    if (rs.start) begin
                        state <= udp_msg_pkg::TX_WAIT_SLOT;
                    end
                end
                udp_msg_pkg::TX_WAIT_SLOT: begin
                    if (tx_req_rdy_i) begin
                        byte_cnt <= '0;
                        state <= udp_msg_pkg::TX_STREAM;
                    end
                end
                udp_msg_pkg::TX_STREAM: begin
                    if (advance) begin
                        if (byte_cnt == udp_msg_pkg::BCNT_FULL) begin
                            // falling av marks the end of the payload
                            tx_data_av_o <= 1'b0;
                            state <= udp_msg_pkg::TX_REQUEST;
                        end else begin
                            tx_data_av_o <= 1'b1;
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                udp_msg_pkg::TX_REQUEST: begin
                    if (tx_req_rdy_i) begin
                        tx_req_o <= 1'b1;
                        state <= udp_msg_pkg::TX_DONE;
                    end
                end
                udp_msg_pkg::TX_DONE: begin
                    tx_req_o <= 1'b0;
                    state <= udp_msg_pkg::TX_IDLE;
                end
                default: begin
                    state <= udp_msg_pkg::TX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == udp_msg_pkg::TX_IDLE && rs.start) begin
            tx_ip_o <= rs.ip;
            tx_dst_port_o <= rs.port;
        end
        // user message sampled once the slot opens
        if (state == udp_msg_pkg::TX_WAIT_SLOT && tx_req_rdy_i) begin
            msg_q <= tx_msg_i;
        end else if (advance && byte_cnt != udp_msg_pkg::BCNT_FULL) begin
            tx_data_o <= msg_q[udp_msg_pkg::MSG_W-1 -: 8];
            msg_q <= {msg_q[udp_msg_pkg::MSG_W-9:0], 8'h00};
        end
    end

    a_data_held: assert property (@(posedge clk) disable iff (!rst_n)
        tx_data_av_o && !tx_data_rdy_i |=> $stable(tx_data_o));

    a_req_single: assert property (@(posedge clk) disable iff (!rst_n)
        tx_req_o |=> !tx_req_o);

endmodule

//--- hw/udp_msg_endpoint.sv
module udp_msg_endpoint (
    input  logic              clk,
    input  logic              rst_n,

    // receive side of the stack
    input  logic              rx_head_av_i,
    input  logic [31:0]       rx_head_i,
    output logic              rx_head_rdy_o,
    input  logic              rx_data_av_i,
    input  logic [7:0]        rx_data_i,

    // transmit side of the stack
    input  logic              tx_req_rdy_i,
    input  logic              tx_data_rdy_i,
    output logic [7:0]        tx_data_o,
    output logic              tx_data_av_o,
    output logic              tx_req_o,
    output logic [31:0]       tx_ip_o,
    output logic [15:0]       tx_dst_port_o,

    // user side
    input  udp_msg_pkg::msg_t tx_msg_i,
    output udp_msg_pkg::msg_t rx_msg_o,
    output logic              msg_valid_o
);

    reply_target_if tgt_if ();
    reply_start_if  rs_if ();

    msg_header_parser u_parser (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_head_av_i  (rx_head_av_i),
        .rx_head_i     (rx_head_i),
        .rx_head_rdy_o (rx_head_rdy_o),
        .tgt           (tgt_if.parser)
    );

    msg_payload_collector u_collector (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_data_av_i (rx_data_av_i),
        .rx_data_i    (rx_data_i),
        .tgt          (tgt_if.collector),
        .rs           (rs_if.collector),
        .rx_msg_o     (rx_msg_o),
        .msg_valid_o  (msg_valid_o)
    );

    msg_reply_sender u_sender (
        .clk           (clk),
        .rst_n         (rst_n),
        .rs            (rs_if.sender),
        .tx_msg_i      (tx_msg_i),
        .tx_req_rdy_i  (tx_req_rdy_i),
        .tx_data_rdy_i (tx_data_rdy_i),
        .tx_data_o     (tx_data_o),
        .tx_data_av_o  (tx_data_av_o),
        .tx_req_o      (tx_req_o),
        .tx_ip_o       (tx_ip_o),
        .tx_dst_port_o (tx_dst_port_o)
    );

endmodule

//--- hw/udp_msg_if.sv
// reply target from the header parser, held for the whole payload
interface reply_target_if;
    logic        valid;
    logic [31:0] ip;
    logic [15:0] port;
    logic        done;

    modport parser (
        output valid,
        output ip,
        output port,
        input  done
    );

    modport collector (
        input  valid,
        input  ip,
        input  port,
        output done
    );
endinterface

// one-shot reply request, ip and port valid with start
interface reply_start_if;
    logic        start;
    logic [31:0] ip;
    logic [15:0] port;
    logic        busy;

    modport collector (
        output start,
        output ip,
        output port,
        input  busy
    );

    modport sender (
        input  start,
        input  ip,
        input  port,
        output busy
    );
endinterface

//--- hw/udp_msg_pkg.sv
package udp_msg_pkg;

    // message format, first received byte in the top bits
    localparam int MSG_BYTES = 5;
    localparam int MSG_W = MSG_BYTES * 8;
    localparam logic [31:0] MSGID = 32'h74697277;

    localparam logic [15:0] LOCAL_PORT = 16'd2390;

    // source ip, length word, ports
    localparam int HEAD_WORDS = 3;

    // byte counter, saturates at MSG_BYTES
    localparam int BCNT_W = $clog2(MSG_BYTES + 1);

    typedef logic [MSG_W-1:0] msg_t;
    typedef logic [BCNT_W-1:0] bcnt_t;

    localparam bcnt_t BCNT_FULL = bcnt_t'(MSG_BYTES);

    typedef enum logic [2:0] {
        HDR_IDLE,
        HDR_IP_WORD,
        HDR_LEN_WORD,
        HDR_PORT_WORD,
        HDR_PAYLOAD
    } hdr_state_e;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_WAIT_SLOT,
        TX_STREAM,
        TX_REQUEST,
        TX_DONE
    } tx_state_e;

endpackage

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_udp_msg_endpoint -f all.f -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1

//--- sim/tb_udp_msg_endpoint.sv
module tb_udp_msg_endpoint;

    typedef logic [7:0] byte_q_t[$];

    typedef struct packed {
        udp_msg_pkg::msg_t msg;
        int                cyc;
        logic [31:0]       ip;
        logic [15:0]       port;
    } exp_t;

    // 200 cycles per datagram
    localparam int N_DGRAMS = 9;
    localparam int LIMIT_CYCLES = N_DGRAMS * 200;
    localparam logic [15:0] LPORT = udp_msg_pkg::LOCAL_PORT;
    localparam udp_msg_pkg::msg_t TX_MSG = 40'hc3_5a_0f_96_e1;

    logic              clk;
    logic              rst_n;
    logic              rx_head_av_i, rx_head_rdy_o, rx_data_av_i;
    logic [31:0]       rx_head_i, tx_ip_o;
    logic [7:0]        rx_data_i, tx_data_o;
    logic              tx_req_rdy_i, tx_data_rdy_i, tx_data_av_o, tx_req_o;
    logic [15:0]       tx_dst_port_o;
    udp_msg_pkg::msg_t tx_msg_i, rx_msg_o;
    logic              msg_valid_o;

    int          cyc = 0;
    int          n_checks = 0;
    int          n_mism = 0;
    int          n_other = 0;
    int          byte_idx = 0;
    bit          pending = 1'b0;
    bit          release_slot = 1'b0;
    bit          req_rdy_last = 1'b0;
    logic        hold_slot;
    logic [31:0] exp_ip;
    logic [15:0] exp_port;
    exp_t        exp_q[$];

    udp_msg_endpoint dut0 (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // message is the last MSG_BYTES bytes and must open with the id
    function automatic bit expect_msg(input byte_q_t bytes, input logic [15:0] dport,
                                      output udp_msg_pkg::msg_t msg);
        int first;
        msg = '0;
        first = bytes.size() - udp_msg_pkg::MSG_BYTES;
        if (dport != udp_msg_pkg::LOCAL_PORT || first < 0) begin
            return 1'b0;
        end
        for (int i = 0; i < udp_msg_pkg::MSG_BYTES; i++) begin
            msg = {msg[udp_msg_pkg::MSG_W-9:0], bytes[first + i]};
        end
        return msg[udp_msg_pkg::MSG_W-1 -: 32] == udp_msg_pkg::MSGID;
    endfunction

    task automatic check_msg(input string name, input udp_msg_pkg::msg_t got,
                             input udp_msg_pkg::msg_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h exp 0x%h", name, got, exp);
            n_mism++;
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h exp 0x%h", name, got, exp);
            n_mism++;
        end
    endtask

    task automatic check_target(input logic [31:0] got_ip, input logic [15:0] got_port,
                                input logic [31:0] want_ip, input logic [15:0] want_port);
        n_checks++;
        if (got_ip !== want_ip || got_port !== want_port) begin
            $display("MISMATCH tx_ip_o/tx_dst_port_o got 0x%h/0x%h exp 0x%h/0x%h",
                     got_ip, got_port, want_ip, want_port);
            n_mism++;
        end
    endtask

    // stack model: header words after rdy, then the payload bytes
    task automatic send_dgram(input logic [31:0] ip, input logic [15:0] sport,
                              input logic [15:0] dport, input byte_q_t bytes);
        exp_t e;
        @(posedge clk);
        rx_head_av_i <= 1'b1;
        rx_head_i <= ip;
        @(negedge clk);
        while (!rx_head_rdy_o) begin
            @(negedge clk);
        end
        @(posedge clk);
        rx_head_av_i <= 1'b0;
        rx_head_i <= 32'h0000_0048;
        @(posedge clk);
        rx_head_i <= {sport, dport};
        foreach (bytes[i]) begin
            @(posedge clk);
            rx_data_av_i <= 1'b1;
            rx_data_i <= bytes[i];
        end
        e.cyc = cyc + 1;
        e.ip = ip;
        e.port = sport;
        if (expect_msg(bytes, dport, e.msg)) begin
            exp_q.push_back(e);
        end
        @(posedge clk);
        rx_data_av_i <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic finish_run(input bit timed_out);
        $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mism, n_other);
        if (!timed_out && n_mism == 0 && n_other == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin : backpressure
        logic [31:0] rnd;
        rnd = 32'h27ff_bb91;
        tx_data_rdy_i <= 1'b0;
        tx_req_rdy_i <= 1'b0;
        forever begin
            @(posedge clk);
            rnd = xorshift32(rnd);
            tx_data_rdy_i <= (rnd[1:0] != 2'b00);
            tx_req_rdy_i <= !hold_slot && (rnd[4:2] != 3'b000);
        end
    end

    always @(negedge clk) begin : compare
        exp_t e;
        if (!rst_n) begin
            check_msg("rx_msg_o", rx_msg_o, '0);
            if (rx_head_rdy_o || msg_valid_o || tx_data_av_o || tx_req_o) begin
                $display("a strobe output is high during reset");
                n_other++;
            end
        end else begin
            if (msg_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("msg_valid_o pulsed although no message was expected");
                    n_other++;
                end else begin
                    e = exp_q.pop_front();
                    check_msg("rx_msg_o", rx_msg_o, e.msg);
                    if (cyc != e.cyc + 2) begin
                        $display("msg_valid_o came in cycle %0d instead of %0d", cyc, e.cyc + 2);
                        n_other++;
                    end
                    // sender stays busy one cycle past the request
                    if (!pending) begin
                        pending = 1'b1;
                        exp_ip = e.ip;
                        exp_port = e.port;
                    end
                end
            end
            if (release_slot) begin
                pending = 1'b0;
                release_slot = 1'b0;
            end
            if (tx_data_av_o && tx_data_rdy_i) begin
                if (!pending || byte_idx >= udp_msg_pkg::MSG_BYTES) begin
                    $display("reply byte sent with no reply byte outstanding");
                    n_other++;
                end else begin
                    check_byte("tx_data_o", tx_data_o,
                               TX_MSG[udp_msg_pkg::MSG_W-1-8*byte_idx -: 8]);
                    byte_idx++;
                end
            end
            if (tx_req_o) begin
                // request only goes out on a sampled slot
                if (!req_rdy_last) begin
                    $display("tx_req_o pulsed although tx_req_rdy_i was low");
                    n_other++;
                end
                if (!pending) begin
                    $display("tx_req_o pulsed with no reply expected");
                    n_other++;
                end else begin
                    check_target(tx_ip_o, tx_dst_port_o, exp_ip, exp_port);
                    if (byte_idx != udp_msg_pkg::MSG_BYTES) begin
                        $display("tx_req_o came after %0d bytes", byte_idx);
                        n_other++;
                    end
                    release_slot = 1'b1;
                end
                byte_idx = 0;
            end
        end
        req_rdy_last = tx_req_rdy_i;
    end

    initial begin : watchdog
        wait (cyc >= LIMIT_CYCLES);
        $display("timeout: the run did not complete within %0d cycles", LIMIT_CYCLES);
        finish_run(1'b1);
    end

    initial begin : stimulus
        rst_n <= 1'b0;
        rx_head_av_i <= 1'b0;
        rx_head_i <= '0;
        rx_data_av_i <= 1'b0;
        rx_data_i <= '0;
        tx_msg_i <= TX_MSG;
        hold_slot <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        send_dgram(32'h0a00_0005, 16'h1f90, LPORT, '{8'h74, 8'h69, 8'h72, 8'h77, 8'h41});
        // wrong port, wrong id, too short
        send_dgram(32'h0a00_0006, 16'h1f91, LPORT + 16'd1, '{8'h74, 8'h69, 8'h72, 8'h77, 8'h41});
        send_dgram(32'h0a00_0007, 16'h1f92, LPORT, '{8'h74, 8'h69, 8'h72, 8'h78, 8'h74});
        // with the 74 left over, the short one lines up with the id
        send_dgram(32'h0a00_0008, 16'h1f93, LPORT, '{8'h69, 8'h72, 8'h77, 8'h41});
        // long ones, judged on the tail
        send_dgram(32'h0a00_0009, 16'h1f94, LPORT,
                   '{8'h11, 8'h22, 8'h74, 8'h69, 8'h72, 8'h77, 8'h5a});
        send_dgram(32'h0a00_000a, 16'h1f95, LPORT,
                   '{8'h74, 8'h69, 8'h72, 8'h77, 8'h41, 8'h42});
        while (pending) begin
            @(posedge clk);
        end
        // second message while the reply waits for its slot
        hold_slot <= 1'b1;
        send_dgram(32'hc0a8_0101, 16'h3000, LPORT, '{8'h74, 8'h69, 8'h72, 8'h77, 8'h01});
        send_dgram(32'hc0a8_0102, 16'h3001, LPORT, '{8'h74, 8'h69, 8'h72, 8'h77, 8'h43});
        hold_slot <= 1'b0;
        send_dgram(32'hc0a8_0103, 16'h3002, LPORT, '{8'h74, 8'h69, 8'h72, 8'h77, 8'h7e});
        while (pending || exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        finish_run(1'b0);
    end

endmodule
